//--- hw/fp_classify.sv
// operand decode: sign, widened exponent, aligned fraction, class flags

`timescale 1ns/1ns

module fp_classify import fpu_pkg::*; (
	input  logic      dbl,
	input  fp_word_t  opnd,
	output fp_class_t cls
);

	logic       boxed;
	logic [7:0] exp_s;
	logic       exp_max, exp_zero, frac_zero, quiet;

	assign boxed = opnd[63:32] == BOX_ONES;
	assign exp_s = opnd[30:23];

	// raw field tests in the native format
	assign exp_max   = dbl ? &opnd[62:52] : &exp_s;
	assign exp_zero  = dbl ? ~|opnd[62:52] : ~|exp_s;
	assign frac_zero = dbl ? ~|opnd[51:0] : ~|opnd[22:0];
	assign quiet     = dbl ? opnd[51] : opnd[22];

	always_comb begin
		cls.unboxed = !dbl && !boxed;
		if (dbl) begin
			cls.sign = opnd[63];
			cls.exp  = opnd[62:52];
			cls.frac = opnd[51:0];
		end else begin
			cls.sign = opnd[31];
			// re-bias 127 to 1023, sub/zero land on 0x380
			cls.exp  = {exp_s[7], {3{~exp_s[7]}}, exp_s[6:0]};
			cls.frac = {opnd[22:0], 29'b0};	// left aligned
		end

		if (cls.unboxed) begin
			// bad box reads as a quiet NaN
			cls.is_nan  = 1'b1;
			cls.is_snan = 1'b0;
			cls.is_inf  = 1'b0;
			cls.is_zero = 1'b0;
			cls.is_sub  = 1'b0;
			cls.is_norm = 1'b0;
		end else begin
			cls.is_nan  = exp_max && !frac_zero;
			cls.is_snan = exp_max && !frac_zero && !quiet;
			cls.is_inf  = exp_max && frac_zero;
			cls.is_zero = exp_zero && frac_zero;
			cls.is_sub  = exp_zero && !frac_zero;
			cls.is_norm = !exp_max && !exp_zero;
		end
	end

endmodule

//--- hw/fp_compare.sv
// FLE/FLT/FEQ and FMIN/FMAX from two classified operands

`timescale 1ns/1ns

module fp_compare import fpu_pkg::*; (
	input  fp_req_t   iss_req,
	input  fp_word_t  iss_fr1,
	input  fp_word_t  iss_fr2,
	input  fp_class_t cls_a,
	input  fp_class_t cls_b,
	output fp_word_t  cmp_res,
	output fp_word_t  minmax_res
);

	logic any_nan, qnan_a, qnan_b;
	logic lt, eq, v;

	assign any_nan = cls_a.is_nan || cls_b.is_nan;
	assign qnan_a  = cls_a.is_nan && !cls_a.is_snan;
	assign qnan_b  = cls_b.is_nan && !cls_b.is_snan;

	// ordering of non-NaN values
	always_comb begin
		lt = 1'b0;
		eq = 1'b0;
		if (cls_a.is_zero && cls_b.is_zero) begin
			eq = 1'b1;	// +0 == -0
		end else if (cls_a.sign != cls_b.sign) begin
			lt = cls_a.sign;
		end else if (cls_a.is_inf || cls_b.is_inf) begin
			if (cls_a.is_inf && cls_b.is_inf)
				eq = 1'b1;
			else
				lt = !(cls_a.is_inf ^ cls_a.sign);
		end else if (cls_a.exp != cls_b.exp) begin
			lt = (cls_a.exp < cls_b.exp) ^ cls_a.sign;	// magnitude flips for negatives
		end else if (cls_a.frac != cls_b.frac) begin
			lt = (cls_a.frac < cls_b.frac) ^ cls_a.sign;
		end else begin
			eq = 1'b1;
		end
	end

	always_comb begin
		case (iss_req.mode)
			2'd0:    v = eq || lt;	// fle
			2'd1:    v = lt;	// flt
			2'd2:    v = eq;	// feq
			default: v = 1'b0;
		endcase
		if (any_nan)
			v = 1'b0;
	end

	assign cmp_res = {63'b0, v};

	// mode bit 0 selects max
	always_comb begin
		if (any_nan) begin
			if (qnan_a && !cls_b.is_nan)
				minmax_res = iss_fr2;
			else if (qnan_b && !cls_a.is_nan)
				minmax_res = iss_fr1;
			else
				minmax_res = iss_req.dbl ? QNAN_D : QNAN_S;
		end else begin
			minmax_res = (lt ^ iss_req.mode[0]) ? iss_fr1 : iss_fr2;
		end
	end

endmodule

//--- hw/fp_issue_reg.sv
// issue stage, captures request, operands and commit tag on enable

`timescale 1ns/1ns

module fp_issue_reg import fpu_pkg::*; #(
	parameter int LN_COMMIT = 5
) (
	input  logic                 clk,
	input  logic                 arst_n,
	input  logic                 enable,
	input  fp_req_t              req,
	input  logic [LN_COMMIT-1:0] rd,
	input  fp_word_t             fr1,
	input  fp_word_t             fr2,
	input  fp_word_t             ir1,
	output logic                 iss_valid,
	output fp_req_t              iss_req,
	output logic [LN_COMMIT-1:0] iss_rd,
	output fp_word_t             iss_fr1,
	output fp_word_t             iss_fr2,
	output fp_word_t             iss_ir1
);

	// start strobe for the compute cycle
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			iss_valid <= 1'b0;
		else
			iss_valid <= enable;
	end

	// payload only moves on a real issue
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			iss_req <= '0;
			iss_rd  <= '0;
			iss_fr1 <= '0;
			iss_fr2 <= '0;
			iss_ir1 <= '0;
		end else if (enable) begin
			iss_req <= req;
			iss_rd  <= rd;
			iss_fr1 <= fr1;
			iss_fr2 <= fr2;
			iss_ir1 <= ir1;	// integer source, fmv only
		end
	end

endmodule

//--- hw/fp_sign_move.sv
// sign injection and FMV between the integer and FP files

`timescale 1ns/1ns

module fp_sign_move import fpu_pkg::*; (
	input  fp_req_t  iss_req,
	input  fp_word_t iss_fr1,
	input  fp_word_t iss_fr2,
	input  fp_word_t iss_ir1,
	output fp_word_t sgn_res,
	output fp_word_t mv_res,
	output logic     mv_to_fp
);

	logic sign_a, sign_b, new_sign;

	assign sign_a = iss_req.dbl ? iss_fr1[63] : iss_fr1[31];
	assign sign_b = iss_req.dbl ? iss_fr2[63] : iss_fr2[31];

	always_comb begin
		case (iss_req.mode)
			2'd1:    new_sign = ~sign_b;	// jn
			2'd2:    new_sign = sign_a ^ sign_b;	// jx
			default: new_sign = sign_b;
		endcase
	end

	// single result gets a fresh box
	assign sgn_res = iss_req.dbl ? {new_sign, iss_fr1[62:0]}
	                             : {BOX_ONES, new_sign, iss_fr1[30:0]};

	always_comb begin
		if (iss_req.to_fp_src)
			mv_res = iss_req.dbl ? iss_ir1 : {BOX_ONES, iss_ir1[31:0]};
		else
			mv_res = iss_req.dbl ? iss_fr1 : {{32{iss_fr1[31]}}, iss_fr1[31:0]};
	end

	assign mv_to_fp = iss_req.to_fp_src;

endmodule

//--- hw/fp_writeback.sv
// FCLASS mask, opcode result select and the output register

`timescale 1ns/1ns

module fp_writeback import fpu_pkg::*; #(
	parameter int LN_COMMIT = 5
) (
	input  logic                 clk,
	input  logic                 arst_n,
	input  logic                 iss_valid,
	input  fp_req_t              iss_req,
	input  logic [LN_COMMIT-1:0] iss_rd,
	input  fp_class_t            cls_a,
	input  fp_word_t             cmp_res,
	input  fp_word_t             minmax_res,
	input  fp_word_t             sgn_res,
	input  fp_word_t             mv_res,
	input  logic                 mv_to_fp,
	output fp_word_t             result,
	output logic [LN_COMMIT-1:0] res_rd,
	output logic                 res_makes_fp,
	output logic                 res_valid
);

	logic [CLASS_WIDTH-1:0] class_mask;
	logic                   supported;
	fp_result_t             c_res, r_res;

	assign class_mask = {
		cls_a.is_nan && !cls_a.is_snan,	// 9 quiet NaN
		cls_a.is_snan,
		!cls_a.sign && cls_a.is_inf,
		!cls_a.sign && cls_a.is_norm,
		!cls_a.sign && cls_a.is_sub,
		!cls_a.sign && cls_a.is_zero,
		cls_a.sign && cls_a.is_zero,
		cls_a.sign && cls_a.is_sub,
		cls_a.sign && cls_a.is_norm,
		cls_a.sign && cls_a.is_inf	// 0 -inf
	};

	always_comb begin
		supported   = 1'b1;
		c_res.value = '0;
		c_res.to_fp = 1'b0;
		case (iss_req.op)
			FP_SGN:    begin c_res.value = sgn_res; c_res.to_fp = 1'b1; end
			FP_MINMAX: begin c_res.value = minmax_res; c_res.to_fp = 1'b1; end
			FP_CMP:    c_res.value = cmp_res;
			FP_CLASS:  c_res.value = fp_word_t'(class_mask);
			FP_MV:     begin c_res.value = mv_res; c_res.to_fp = mv_to_fp; end
			default:   supported = 1'b0;	// no write
		endcase
		c_res.valid = iss_valid && supported;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			r_res  <= '0;
			res_rd <= '0;
		end else begin
			r_res.valid <= c_res.valid;
			if (iss_valid) begin	// hold last value between results
				r_res.value <= c_res.value;
				r_res.to_fp <= c_res.to_fp;
				res_rd      <= iss_rd;
			end
		end
	end

	assign result       = r_res.value;
	assign res_makes_fp = r_res.to_fp;
	assign res_valid    = r_res.valid;

endmodule

//--- hw/fpu_misc.sv
// top level of the single-cycle FP unit
// issue register, two classifiers, compare, sign/move and writeback

`timescale 1ns/1ns

module fpu_misc import fpu_pkg::*; #(
	parameter int LN_COMMIT = 5
) (
	input  logic                 clk,
	input  logic                 arst_n,
	input  logic                 enable,
	input  fp_req_t              req,
	input  logic [LN_COMMIT-1:0] rd,
	input  fp_word_t             fr1,
	input  fp_word_t             fr2,
	input  fp_word_t             ir1,
	output fp_word_t             result,
	output logic [LN_COMMIT-1:0] res_rd,
	output logic                 res_makes_fp,
	output logic                 res_valid
);

	logic                 iss_valid;
	fp_req_t              iss_req;
	logic [LN_COMMIT-1:0] iss_rd;
	fp_word_t             iss_fr1, iss_fr2, iss_ir1;
	fp_class_t            cls_a, cls_b;
	fp_word_t             cmp_res, minmax_res, sgn_res, mv_res;
	logic                 mv_to_fp;

	fp_issue_reg #(.LN_COMMIT(LN_COMMIT)) fp_issue_reg_i (
		.clk(clk), .arst_n(arst_n), .enable(enable), .req(req), .rd(rd),
		.fr1(fr1), .fr2(fr2), .ir1(ir1),
		.iss_valid(iss_valid), .iss_req(iss_req), .iss_rd(iss_rd),
		.iss_fr1(iss_fr1), .iss_fr2(iss_fr2), .iss_ir1(iss_ir1)
	);

	fp_classify fp_classify_a (.dbl(iss_req.dbl), .opnd(iss_fr1), .cls(cls_a));
	fp_classify fp_classify_b (.dbl(iss_req.dbl), .opnd(iss_fr2), .cls(cls_b));

	fp_compare fp_compare_i (
		.iss_req(iss_req), .iss_fr1(iss_fr1), .iss_fr2(iss_fr2),
		.cls_a(cls_a), .cls_b(cls_b), .cmp_res(cmp_res), .minmax_res(minmax_res)
	);

	fp_sign_move fp_sign_move_i (
		.iss_req(iss_req), .iss_fr1(iss_fr1), .iss_fr2(iss_fr2), .iss_ir1(iss_ir1),
		.sgn_res(sgn_res), .mv_res(mv_res), .mv_to_fp(mv_to_fp)
	);

	fp_writeback #(.LN_COMMIT(LN_COMMIT)) fp_writeback_i (
		.clk(clk), .arst_n(arst_n),
		.iss_valid(iss_valid), .iss_req(iss_req), .iss_rd(iss_rd), .cls_a(cls_a),
		.cmp_res(cmp_res), .minmax_res(minmax_res), .sgn_res(sgn_res),
		.mv_res(mv_res), .mv_to_fp(mv_to_fp),
		.result(result), .res_rd(res_rd), .res_makes_fp(res_makes_fp),
		.res_valid(res_valid)
	);

endmodule

//--- hw/fpu_pkg.sv
// shared types and constants for the single-cycle FP unit
// words, opcodes, request, operand class and result records

package fpu_pkg;

	typedef logic [63:0] fp_word_t;	// register-file word
	typedef logic [10:0] fp_exp_t;	// double-width exponent
	typedef logic [51:0] fp_frac_t;	// double-width fraction

	// opcode encodings as used by the decoder
	typedef enum logic [3:0] {
		FP_SGN    = 4'd5,
		FP_MINMAX = 4'd6,
		FP_CMP    = 4'd12,
		FP_CLASS  = 4'd13,
		FP_MV     = 4'd14
	} fp_op_t;

	typedef struct packed {
		fp_op_t     op;
		logic [1:0] mode;	// sign mode, compare kind, or min/max in bit 0
		logic       dbl;	// 1 double, 0 single
		logic       to_fp_src;	// fmv direction, 1 int to fp
	} fp_req_t;

	typedef struct packed {
		logic     sign;
		fp_exp_t  exp;
		fp_frac_t frac;
		logic     is_nan;
		logic     is_snan;
		logic     is_inf;
		logic     is_zero;
		logic     is_sub;
		logic     is_norm;
		logic     unboxed;	// single without a valid NaN box
	} fp_class_t;

	typedef struct packed {
		fp_word_t value;
		logic     to_fp;
		logic     valid;
	} fp_result_t;

	localparam logic [31:0] BOX_ONES = 32'hffff_ffff;
	localparam fp_word_t QNAN_D = 64'h7ff8_0000_0000_0000;
	localparam fp_word_t QNAN_S = 64'hffff_ffff_7fc0_0000;
	localparam int CLASS_WIDTH = 10;

endpackage

//--- run.sh
#!/usr/bin/env bash
# build the FP unit testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary -j 0 --top-module tb_fpu_misc -f src.f -o sim_tb

out=$(./obj_dir/sim_tb 2>&1) || true
echo "$out"

if echo "$out" | grep -q "TEST RESULT: PASS"; then
	exit 0
fi
exit 1

//--- src.f
hw/fpu_pkg.sv
hw/fp_issue_reg.sv
hw/fp_classify.sv
hw/fp_compare.sv
hw/fp_sign_move.sv
hw/fp_writeback.sv
hw/fpu_misc.sv
tests/tb_clock.sv
tests/tb_fpu_misc.sv

//--- tests/tb_clock.sv
// free-running testbench clock

`timescale 1ns/1ns

module tb_clock #(
	parameter int PERIOD = 8
) (
	output logic clk
);

	initial clk = 1'b0;

	always #(PERIOD / 2) clk = ~clk;	// 50% duty

endmodule

//--- tests/tb_fpu_misc.sv
// testbench top for the FP unit
// vector table, drive and check loops, compare tasks and watchdog

`timescale 1ns/1ns

module tb_fpu_misc import fpu_pkg::*; ();

	localparam int TAG_W = 6;	// one tag per row
	localparam int CLK_PERIOD = 8;

	// operand encodings, singles boxed
	localparam fp_word_t D_ONE    = 64'h3ff0_0000_0000_0000;
	localparam fp_word_t D_ONE_N  = 64'hbff0_0000_0000_0000;
	localparam fp_word_t D_TWO    = 64'h4000_0000_0000_0000;
	localparam fp_word_t D_TWO_N  = 64'hc000_0000_0000_0000;
	localparam fp_word_t D_INF    = 64'h7ff0_0000_0000_0000;
	localparam fp_word_t D_INF_N  = 64'hfff0_0000_0000_0000;
	localparam fp_word_t D_SNAN   = 64'h7ff0_0000_0000_0001;
	localparam fp_word_t S_ONE    = 64'hffff_ffff_3f80_0000;
	localparam fp_word_t S_ONE_N  = 64'hffff_ffff_bf80_0000;
	localparam fp_word_t S_TWO    = 64'hffff_ffff_4000_0000;
	localparam fp_word_t S_TWO_N  = 64'hffff_ffff_c000_0000;
	localparam fp_word_t S_SNAN   = 64'hffff_ffff_7f80_0001;
	localparam fp_word_t INT_WORD = 64'h1234_5678_dead_beef;

	// one operand per FCLASS bit, bit 0 first
	localparam fp_word_t CLS_D [CLASS_WIDTH] = '{
		D_INF_N, D_ONE_N, 64'h8000_0000_0000_0001, 64'h8000_0000_0000_0000,
		64'h0, 64'h1, D_ONE, D_INF, D_SNAN, QNAN_D
	};
	localparam fp_word_t CLS_S [CLASS_WIDTH] = '{
		64'hffff_ffff_ff80_0000, S_ONE_N, 64'hffff_ffff_8000_0001,
		64'hffff_ffff_8000_0000, 64'hffff_ffff_0000_0000, 64'hffff_ffff_0000_0001,
		S_ONE, 64'hffff_ffff_7f80_0000, S_SNAN, QNAN_S
	};

	typedef struct packed {
		fp_req_t  req;
		fp_word_t fr1;
		fp_word_t fr2;
		fp_word_t ir1;
		fp_word_t exp_val;
		logic     exp_fp;
		logic     exp_valid;
	} row_t;

	row_t rows[$];
	bit   table_ready = 1'b0;

	logic             clk, arst_n, enable;
	fp_req_t          req;
	logic [TAG_W-1:0] rd, res_rd;
	fp_word_t         fr1, fr2, ir1, result;
	logic             res_makes_fp, res_valid;

	tb_clock #(.PERIOD(CLK_PERIOD)) tb_clock_i (.clk(clk));

	fpu_misc #(.LN_COMMIT(TAG_W)) fpu_misc_i (
		.clk(clk), .arst_n(arst_n), .enable(enable), .req(req), .rd(rd),
		.fr1(fr1), .fr2(fr2), .ir1(ir1), .result(result), .res_rd(res_rd),
		.res_makes_fp(res_makes_fp), .res_valid(res_valid)
	);

	function automatic fp_req_t make_req(int op, int mode, int dbl, int to_fp);
		return {op[3:0], mode[1:0], dbl[0], to_fp[0]};
	endfunction

	task automatic add_row(fp_req_t r, fp_word_t a, fp_word_t b, fp_word_t ir,
			fp_word_t val, int to_fp, int valid);
		row_t w;
		w.req       = r;
		w.fr1       = a;
		w.fr2       = b;
		w.ir1       = ir;
		w.exp_val   = val;
		w.exp_fp    = to_fp[0];
		w.exp_valid = valid[0];
		rows.push_back(w);
	endtask

	task automatic build_table();
		// sign injection, J JN JX
		add_row(make_req(FP_SGN, 0, 1, 0), D_ONE_N, D_TWO, '0, D_ONE, 1, 1);
		add_row(make_req(FP_SGN, 1, 1, 0), D_ONE_N, D_TWO_N, '0, D_ONE, 1, 1);
		add_row(make_req(FP_SGN, 2, 1, 0), D_ONE, D_TWO_N, '0, D_ONE_N, 1, 1);
		add_row(make_req(FP_SGN, 0, 0, 0), S_ONE, S_TWO_N, '0, S_ONE_N, 1, 1);
		add_row(make_req(FP_SGN, 1, 0, 0), S_ONE, S_TWO, '0, S_ONE_N, 1, 1);
		add_row(make_req(FP_SGN, 2, 0, 0), S_ONE_N, S_TWO_N, '0, S_ONE, 1, 1);
		// fmv both ways
		add_row(make_req(FP_MV, 0, 1, 1), D_TWO, '0, INT_WORD, INT_WORD, 1, 1);
		add_row(make_req(FP_MV, 0, 0, 1), S_TWO, '0, INT_WORD, 64'hffff_ffff_dead_beef, 1, 1);
		add_row(make_req(FP_MV, 0, 1, 0), D_TWO_N, '0, INT_WORD, D_TWO_N, 0, 1);
		add_row(make_req(FP_MV, 0, 0, 0), S_ONE, '0, INT_WORD, 64'h0000_0000_3f80_0000, 0, 1);
		add_row(make_req(FP_MV, 0, 0, 0), S_ONE_N, '0, INT_WORD, S_ONE_N, 0, 1);
		add_row(make_req(3, 0, 1, 0), D_ONE, D_TWO, '0, '0, 0, 0);	// no write
		// compares, mode 0 le 1 lt 2 eq
		add_row(make_req(FP_CMP, 0, 1, 0), D_ONE, D_TWO, '0, 64'd1, 0, 1);
		add_row(make_req(FP_CMP, 0, 1, 0), D_TWO_N, D_TWO_N, '0, 64'd1, 0, 1);
		add_row(make_req(FP_CMP, 1, 1, 0), D_ONE_N, D_ONE, '0, 64'd1, 0, 1);
		add_row(make_req(FP_CMP, 1, 1, 0), D_TWO_N, D_ONE_N, '0, 64'd1, 0, 1);
		add_row(make_req(FP_CMP, 0, 1, 0), D_INF, D_TWO, '0, 64'd0, 0, 1);
		add_row(make_req(FP_CMP, 1, 1, 0), D_INF_N, D_TWO_N, '0, 64'd1, 0, 1);
		add_row(make_req(FP_CMP, 1, 1, 0), D_ONE, 64'h3ff8_0000_0000_0000, '0, 64'd1, 0, 1);
		add_row(make_req(FP_CMP, 2, 1, 0), D_ONE, 64'h3ff8_0000_0000_0000, '0, 64'd0, 0, 1);
		add_row(make_req(FP_CMP, 2, 1, 0), 64'h0, 64'h8000_0000_0000_0000, '0, 64'd1, 0, 1);
		add_row(make_req(FP_CMP, 1, 1, 0), 64'h8000_0000_0000_0000, 64'h0, '0, 64'd0, 0, 1);
		add_row(make_req(FP_CMP, 1, 1, 0), D_ONE, QNAN_D, '0, 64'd0, 0, 1);
		add_row(make_req(FP_CMP, 1, 0, 0), S_ONE, 64'hffff_ffff_3fc0_0000, '0, 64'd1, 0, 1);
		add_row(make_req(FP_CMP, 2, 0, 0), S_SNAN, S_SNAN, '0, 64'd0, 0, 1);
		// min and max, mode bit 0 picks max
		add_row(make_req(FP_MINMAX, 0, 1, 0), D_ONE, D_TWO, '0, D_ONE, 1, 1);
		add_row(make_req(FP_MINMAX, 1, 1, 0), D_ONE, D_TWO, '0, D_TWO, 1, 1);
		add_row(make_req(FP_MINMAX, 1, 1, 0), D_INF_N, D_ONE_N, '0, D_ONE_N, 1, 1);
		add_row(make_req(FP_MINMAX, 0, 0, 0), 64'hffff_ffff_3fc0_0000, S_ONE, '0, S_ONE, 1, 1);
		add_row(make_req(FP_MINMAX, 1, 1, 0), QNAN_D, D_ONE, '0, D_ONE, 1, 1);
		add_row(make_req(FP_MINMAX, 0, 1, 0), D_TWO, QNAN_D, '0, D_TWO, 1, 1);
		add_row(make_req(FP_MINMAX, 0, 1, 0), D_SNAN, D_ONE, '0, QNAN_D, 1, 1);
		add_row(make_req(FP_MINMAX, 1, 1, 0), 64'h7ff8_0000_0000_0001,
			64'hfff8_0000_0000_0002, '0, QNAN_D, 1, 1);	// payloads dropped
		add_row(make_req(0, 0, 1, 0), D_ONE, D_TWO, '0, '0, 0, 0);	// no write
		add_row(make_req(FP_MINMAX, 0, 0, 0), 64'h0000_0000_3f80_0000, S_TWO, '0, S_TWO, 1, 1);
		add_row(make_req(FP_MINMAX, 1, 0, 0), S_SNAN, S_ONE, '0, QNAN_S, 1, 1);
		for (int i = 0; i < CLASS_WIDTH; i++) begin
			add_row(make_req(FP_CLASS, 0, 1, 0), CLS_D[i], '0, '0, 64'd1 << i, 0, 1);
			add_row(make_req(FP_CLASS, 0, 0, 0), CLS_S[i], '0, '0, 64'd1 << i, 0, 1);
		end
		// broken box classifies as quiet NaN
		add_row(make_req(FP_CLASS, 0, 0, 0), 64'h0000_0000_3f80_0000, '0, '0, 64'h200, 0, 1);
	endtask

	task automatic stop_run(string why);
		$display("TEST RESULT: FAIL");
		$fatal(1, "%s", why);
	endtask

	task automatic check_word(string name, fp_word_t exp, fp_word_t act);
		if (act !== exp) begin
			$display("FAIL at %0t ns %s expected %h got %h", $time, name, exp, act);
			stop_run("result word mismatch");
		end
	endtask

	task automatic check_bit(string name, logic exp, logic act);
		if (act !== exp) begin
			$display("FAIL at %0t ns %s expected %b got %b", $time, name, exp, act);
			stop_run("flag mismatch");
		end
	endtask

	task automatic check_tag(string name, logic [TAG_W-1:0] exp, logic [TAG_W-1:0] act);
		if (act !== exp) begin
			$display("FAIL at %0t ns %s expected %0d got %0d", $time, name, exp, act);
			stop_run("destination tag mismatch");
		end
	endtask

	task automatic drive_rows();
		for (int i = 0; i < rows.size(); i++) begin
			@(posedge clk);
			enable <= 1'b1;	// back to back issue
			req    <= rows[i].req;
			rd     <= i[TAG_W-1:0];
			fr1    <= rows[i].fr1;
			fr2    <= rows[i].fr2;
			ir1    <= rows[i].ir1;
		end
		@(posedge clk);
		enable <= 1'b0;
	endtask

	task automatic check_rows();
		repeat (2) @(posedge clk);
		for (int i = 0; i < rows.size(); i++) begin
			@(posedge clk);
			@(negedge clk);	// two edges after the row went in
			check_bit("res_valid", rows[i].exp_valid, res_valid);
			if (rows[i].exp_valid) begin
				check_word("result", rows[i].exp_val, result);
				check_bit("res_makes_fp", rows[i].exp_fp, res_makes_fp);
				check_tag("res_rd", i[TAG_W-1:0], res_rd);
			end
		end
	endtask

	initial begin
		arst_n = 1'b0;
		enable = 1'b0;
		req    = '0;
		rd     = '0;
		fr1    = '0;
		fr2    = '0;
		ir1    = '0;
		build_table();
		table_ready = 1'b1;
		repeat (5) @(posedge clk);
		arst_n <= 1'b1;
		@(negedge clk);	// nothing issued yet
		check_bit("res_valid", 1'b0, res_valid);
		check_word("result", '0, result);
		check_tag("res_rd", '0, res_rd);
		check_bit("res_makes_fp", 1'b0, res_makes_fp);
		fork
			drive_rows();
			check_rows();
		join
		@(negedge clk);	// pipeline drained
		check_bit("res_valid", 1'b0, res_valid);
		$display("TEST RESULT: PASS");
		$finish;
	end

	// watchdog sized from the table length
	initial begin
		wait (table_ready);
		#((rows.size() + 20) * CLK_PERIOD);
		$display("run timed out before all %0d rows were checked", rows.size());
		stop_run("watchdog expired");
	end

endmodule
